//--- Makefile
# verilator lint, build and run of the image filter testbench

TOP := tb_image_filter

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sim.f

# the run passes only when the pass line shows up in the output
sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sim.f -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Test OK"

clean:
	rm -rf obj_dir

//--- filter_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared definitions for the image filter processing side
// filter selection enum, pixel channel width, key count and the constants
// for key debouncing and the brightness filter
// referenced by scoped name from the rtl and the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package filter_pkg;

    // filter choice, one per key
    // key 0 colour, key 1 blur, key 2 brightness, key 3 edges
    typedef enum logic [1:0] {
        COLOUR     = 2'd0,
        BLUR       = 2'd1,
        BRIGHTNESS = 2'd2,
        EDGES      = 2'd3
    } filter_e;

    // number of push keys on the board
    localparam int KEY_COUNT = 4;

    // width of one colour channel
    localparam int PIXEL_W = 8;

    // largest channel value, used for saturation
    localparam logic [PIXEL_W-1:0] PIXEL_MAX = '1;

    // clk cycles between key sample strobes
    // kept small so simulation stays short, a board build would use a much
    // larger divide
    localparam int TICK_DIV = 4;

    // width of the sample tick counter
    localparam int TICK_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    // consecutive agreeing samples before the debounced level flips
    localparam int DEBOUNCE_COUNT = 3;

    // width of the debounce stability counter
    localparam int DEBOUNCE_W = $clog2(DEBOUNCE_COUNT + 1);

    // added to each channel by the brightness filter
    localparam logic [PIXEL_W-1:0] BRIGHT_OFFSET = PIXEL_W'(48);

endpackage

//--- filter_select_fsm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// filter selection state machine
// keeps the current filter and moves to the filter of a pressed key
// the lowest key index wins when several press pulses arrive together
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module filter_select_fsm (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [filter_pkg::KEY_COUNT-1:0] press,
    output filter_pkg::filter_e              filter_type
);

    filter_pkg::filter_e state;
    filter_pkg::filter_e state_next;

    // key to filter mapping
    // key 0 colour, key 1 blur, key 2 brightness, key 3 edges
    always_comb begin
        state_next = state;
        if (press[0]) begin
            state_next = filter_pkg::COLOUR;
        end else if (press[1]) begin
            state_next = filter_pkg::BLUR;
        end else if (press[2]) begin
            state_next = filter_pkg::BRIGHTNESS;
        end else if (press[3]) begin
            state_next = filter_pkg::EDGES;
        end
    end

    // start on colour, which passes pixels through
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= filter_pkg::COLOUR;
        end else begin
            state <= state_next;
        end
    end

    assign filter_type = state;

    // key 0 overrides any other key pressed in the same cycle
    a_key0_colour: assert property (@(posedge clk) disable iff (reset)
        press[0] |=> (filter_type == filter_pkg::COLOUR));

endmodule

//--- image_filter_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// image filter processing top level
// four keys pick the filter, the pixel stream is filtered with two cycles of
// latency, only plain ports so it drops into a board top or a testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module image_filter_top (
    input  logic                             clk,
    input  logic                             reset,
    // active high, pressed
    input  logic [filter_pkg::KEY_COUNT-1:0] key,
    input  logic                             pixel_valid,
    input  logic                             line_start,
    input  logic [filter_pkg::PIXEL_W-1:0]   in_r,
    input  logic [filter_pkg::PIXEL_W-1:0]   in_g,
    input  logic [filter_pkg::PIXEL_W-1:0]   in_b,
    output logic                             out_valid,
    output logic [filter_pkg::PIXEL_W-1:0]   out_r,
    output logic [filter_pkg::PIXEL_W-1:0]   out_g,
    output logic [filter_pkg::PIXEL_W-1:0]   out_b,
    output filter_pkg::filter_e              filter_type
);

    // shared key sample strobe
    logic sample_en;

    // one press pulse per key
    logic [filter_pkg::KEY_COUNT-1:0] press;

    sample_tick i_sample_tick (
        .clk       (clk),
        .reset     (reset),
        .sample_en (sample_en)
    );

    // identical conditioner per key, all on the same strobe
    for (genvar i = 0; i < filter_pkg::KEY_COUNT; i++) begin : g_key
        key_conditioner i_key_conditioner (
            .clk       (clk),
            .reset     (reset),
            .sample_en (sample_en),
            .key       (key[i]),
            .pressed   (),
            .press     (press[i])
        );
    end

    filter_select_fsm i_filter_select_fsm (
        .clk         (clk),
        .reset       (reset),
        .press       (press),
        .filter_type (filter_type)
    );

    // filter is sampled together with each pixel
    pixel_filter i_pixel_filter (
        .clk         (clk),
        .reset       (reset),
        .filter_type (filter_type),
        .pixel_valid (pixel_valid),
        .line_start  (line_start),
        .in_r        (in_r),
        .in_g        (in_g),
        .in_b        (in_b),
        .out_valid   (out_valid),
        .out_r       (out_r),
        .out_g       (out_g),
        .out_b       (out_b)
    );

endmodule

//--- key_conditioner.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// conditioning for one push key
// two flop synchroniser, sample based debounce and rising edge detect
// pressed is the debounced level, press a one-cycle pulse per key press
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module key_conditioner (
    input  logic clk,
    input  logic reset,
    input  logic sample_en,
    input  logic key,
    output logic pressed,
    output logic press
);

    // synchroniser stages, key is asynchronous to clk
    logic key_meta;
    logic key_sync;

    // samples in a row that disagree with the debounced level
    logic [filter_pkg::DEBOUNCE_W-1:0] stable_cnt;

    // debounced level one cycle back, for edge detect
    logic pressed_d;

    // count value at which the next agreeing sample flips the level
    localparam logic [filter_pkg::DEBOUNCE_W-1:0] STABLE_LAST =
        filter_pkg::DEBOUNCE_W'(filter_pkg::DEBOUNCE_COUNT - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            key_meta <= 1'b0;
            key_sync <= 1'b0;
        end else begin
            key_meta <= key;
            key_sync <= key_meta;
        end
    end

    // debounce
    // any sample back at the current level restarts the count, so a short
    // glitch never collects DEBOUNCE_COUNT samples
    always_ff @(posedge clk) begin
        if (reset) begin
            stable_cnt <= '0;
            pressed    <= 1'b0;
        end else if (key_sync == pressed) begin
            stable_cnt <= '0;
        end else if (sample_en) begin
            if (stable_cnt == STABLE_LAST) begin
                // enough samples agree, take the new level
                stable_cnt <= '0;
                pressed    <= key_sync;
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

    // rising edge of the debounced level, one cycle behind it
    always_ff @(posedge clk) begin
        if (reset) begin
            pressed_d <= 1'b0;
            press     <= 1'b0;
        end else begin
            pressed_d <= pressed;
            press     <= pressed & ~pressed_d;
        end
    end

    // one pulse per press, the level must drop before another edge
    a_press_single: assert property (@(posedge clk) disable iff (reset)
        press |=> !press);

endmodule

//--- pixel_filter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two stage rgb pixel filter pipeline
// stage 1 registers the pixel, its filter and the previous pixel on the line
// stage 2 applies colour, blur, brightness or edges per channel
// fixed latency of two cycles, a new pixel may enter every cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module pixel_filter (
    input  logic                           clk,
    input  logic                           reset,
    input  filter_pkg::filter_e            filter_type,
    input  logic                           pixel_valid,
    input  logic                           line_start,
    input  logic [filter_pkg::PIXEL_W-1:0] in_r,
    input  logic [filter_pkg::PIXEL_W-1:0] in_g,
    input  logic [filter_pkg::PIXEL_W-1:0] in_b,
    output logic                           out_valid,
    output logic [filter_pkg::PIXEL_W-1:0] out_r,
    output logic [filter_pkg::PIXEL_W-1:0] out_g,
    output logic [filter_pkg::PIXEL_W-1:0] out_b
);

    // stage 1 state
    logic                           s1_valid;
    filter_pkg::filter_e            s1_filter;
    logic [filter_pkg::PIXEL_W-1:0] s1_r;
    logic [filter_pkg::PIXEL_W-1:0] s1_g;
    logic [filter_pkg::PIXEL_W-1:0] s1_b;
    logic [filter_pkg::PIXEL_W-1:0] s1_prev_r;
    logic [filter_pkg::PIXEL_W-1:0] s1_prev_g;
    logic [filter_pkg::PIXEL_W-1:0] s1_prev_b;

    // one channel of the filter
    function automatic logic [filter_pkg::PIXEL_W-1:0] apply_filter(
        input filter_pkg::filter_e            mode,
        input logic [filter_pkg::PIXEL_W-1:0] cur,
        input logic [filter_pkg::PIXEL_W-1:0] prev
    );
        logic [filter_pkg::PIXEL_W:0]   sum;
        logic [filter_pkg::PIXEL_W-1:0] result;
        case (mode)
            filter_pkg::BLUR: begin
                // floor of the mean, carry kept in the extra bit
                sum    = {1'b0, cur} + {1'b0, prev};
                result = sum[filter_pkg::PIXEL_W:1];
            end
            filter_pkg::BRIGHTNESS: begin
                sum = {1'b0, cur} + {1'b0, filter_pkg::BRIGHT_OFFSET};
                // saturate on carry out
                if (sum[filter_pkg::PIXEL_W]) begin
                    result = filter_pkg::PIXEL_MAX;
                end else begin
                    result = sum[filter_pkg::PIXEL_W-1:0];
                end
            end
            filter_pkg::EDGES: begin
                // absolute difference to the left neighbour
                if (cur >= prev) begin
                    result = cur - prev;
                end else begin
                    result = prev - cur;
                end
            end
            default: begin
                // colour, straight through
                result = cur;
            end
        endcase
        return result;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= pixel_valid;
        end
    end

    // stage 1 payload only loads on a valid pixel, so s1_r/g/b always hold
    // the last pixel seen and serve as the left neighbour of the next one
    always_ff @(posedge clk) begin
        if (pixel_valid) begin
            s1_filter <= filter_type;
            s1_r      <= in_r;
            s1_g      <= in_g;
            s1_b      <= in_b;
            if (line_start) begin
                // first pixel of a line is its own neighbour
                s1_prev_r <= in_r;
                s1_prev_g <= in_g;
                s1_prev_b <= in_b;
            end else begin
                s1_prev_r <= s1_r;
                s1_prev_g <= s1_g;
                s1_prev_b <= s1_b;
            end
        end
    end

    // stage 2
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            out_r <= apply_filter(s1_filter, s1_r, s1_prev_r);
            out_g <= apply_filter(s1_filter, s1_g, s1_prev_g);
            out_b <= apply_filter(s1_filter, s1_b, s1_prev_b);
        end
    end

    // every pixel leaves exactly two cycles after it enters
    a_latency: assert property (@(posedge clk) disable iff (reset)
        ##2 (out_valid == $past(pixel_valid, 2)));

endmodule

//--- sample_tick.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// key sample strobe generator
// divides clk down to a one-cycle pulse every TICK_DIV cycles, shared by
// all key conditioners so they sample on the same cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sample_tick (
    input  logic clk,
    input  logic reset,
    output logic sample_en
);

    // free running divide counter
    logic [filter_pkg::TICK_W-1:0] tick_cnt;

    // last count value before the wrap
    localparam logic [filter_pkg::TICK_W-1:0] TICK_LAST =
        filter_pkg::TICK_W'(filter_pkg::TICK_DIV - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            tick_cnt  <= '0;
            sample_en <= 1'b0;
        end else begin
            // pulse on the wrap, low on every other cycle
            if (tick_cnt == TICK_LAST) begin
                tick_cnt  <= '0;
                sample_en <= 1'b1;
            end else begin
                tick_cnt  <= tick_cnt + 1'b1;
                sample_en <= 1'b0;
            end
        end
    end

endmodule

//--- sim.f
filter_pkg.sv
sample_tick.sv
key_conditioner.sv
filter_select_fsm.sv
pixel_filter.sv
image_filter_top.sv
tb_checker.sv
tb_image_filter.sv

//--- tb_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// checker for the image filter testbench
// watches the DUT ports, models the key selection and the pixel filters
// and compares every output pixel and every requested selection check
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_checker (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [filter_pkg::KEY_COUNT-1:0] key,
    input  logic                             pixel_valid,
    input  logic                             line_start,
    input  logic [filter_pkg::PIXEL_W-1:0]   in_r,
    input  logic [filter_pkg::PIXEL_W-1:0]   in_g,
    input  logic [filter_pkg::PIXEL_W-1:0]   in_b,
    input  logic                             out_valid,
    input  logic [filter_pkg::PIXEL_W-1:0]   out_r,
    input  logic [filter_pkg::PIXEL_W-1:0]   out_g,
    input  logic [filter_pkg::PIXEL_W-1:0]   out_b,
    input  filter_pkg::filter_e              filter_type,
    input  logic                             check_sel,
    output int                               error_count,
    output int                               check_count,
    output int                               in_flight
);

    // a key held this many cycles is always taken
    localparam int SELECT_HOLD = 20;

    filter_pkg::filter_e model_filter;
    int run [filter_pkg::KEY_COUNT];
    int cycle;
    int last_r;
    int last_g;
    int last_b;

    // no key is inside its debounce window
    logic settled;
    // filter of the lowest key still debouncing
    filter_pkg::filter_e pending;
    // filter that applies to the pixel entering now
    filter_pkg::filter_e pixel_sel;

    // expected channels and entry cycle of each pixel in flight
    int exp_r_q[$];
    int exp_g_q[$];
    int exp_b_q[$];
    int entry_q[$];

    function automatic filter_pkg::filter_e key_filter(input int k);
        case (k)
            0: return filter_pkg::COLOUR;
            1: return filter_pkg::BLUR;
            2: return filter_pkg::BRIGHTNESS;
            default: return filter_pkg::EDGES;
        endcase
    endfunction

    // reference filter for one channel
    function automatic int model_channel(input filter_pkg::filter_e mode,
                                         input int cur, input int prev);
        int bright;
        bright = cur + int'(filter_pkg::BRIGHT_OFFSET);
        case (mode)
            filter_pkg::BLUR: return (cur + prev) / 2;
            filter_pkg::BRIGHTNESS:
                return (bright > int'(filter_pkg::PIXEL_MAX)) ?
                    int'(filter_pkg::PIXEL_MAX) : bright;
            filter_pkg::EDGES: return (cur > prev) ? cur - prev : prev - cur;
            default: return cur;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("FAILED at %0t ns: %s expected %0d got %0d", $time, name, expected, actual);
        error_count++;
    endtask

    task automatic compare_channel(input string name, input int expected,
                                   input logic [filter_pkg::PIXEL_W-1:0] actual);
        if (actual !== filter_pkg::PIXEL_W'(expected)) begin
            report_mismatch(name, expected, int'(actual));
        end
    endtask

    always @(posedge clk) begin
        cycle++;
        if (reset) begin
            model_filter = filter_pkg::COLOUR;
            for (int k = 0; k < filter_pkg::KEY_COUNT; k++) begin
                run[k] = 0;
            end
            exp_r_q.delete();
            exp_g_q.delete();
            exp_b_q.delete();
            entry_q.delete();
        end else begin
            // selection model, walked downwards so the lowest key wins
            for (int k = filter_pkg::KEY_COUNT - 1; k >= 0; k--) begin
                if (key[k]) begin
                    if (run[k] == SELECT_HOLD - 1) begin
                        model_filter = key_filter(k);
                    end
                    if (run[k] < SELECT_HOLD) begin
                        run[k]++;
                    end
                end else begin
                    run[k] = 0;
                end
            end
            // a key mid debounce may or may not have been taken yet
            settled = 1'b1;
            pending = model_filter;
            for (int k = filter_pkg::KEY_COUNT - 1; k >= 0; k--) begin
                if (run[k] != 0 && run[k] != SELECT_HOLD) begin
                    settled = 1'b0;
                    pending = key_filter(k);
                end
            end
            // filter_type follows the model, or the pending key while it debounces
            if (filter_type !== model_filter && (settled || filter_type !== pending)) begin
                report_mismatch("filter_type", int'(model_filter), int'(filter_type));
            end
            if (check_sel) begin
                check_count++;
                if (filter_type !== model_filter) begin
                    report_mismatch("filter_type", int'(model_filter), int'(filter_type));
                end
                // nothing in flight, nothing may come out
                if (exp_r_q.size() == 0 && out_valid !== 1'b0) begin
                    report_mismatch("out_valid", 0, int'(out_valid));
                end
            end
            if (out_valid) begin
                if (exp_r_q.size() == 0) begin
                    $display("FAILED at %0t ns: output pixel with no pixel in flight", $time);
                    error_count++;
                end else begin
                    check_count++;
                    compare_channel("out_r", exp_r_q.pop_front(), out_r);
                    compare_channel("out_g", exp_g_q.pop_front(), out_g);
                    compare_channel("out_b", exp_b_q.pop_front(), out_b);
                    if (cycle - entry_q[0] != 2) begin
                        report_mismatch("latency", 2, cycle - entry_q[0]);
                    end
                    void'(entry_q.pop_front());
                end
            end
            if (pixel_valid) begin
                // model filter once settled, the checked filter_type while a key debounces
                pixel_sel = settled ? model_filter : filter_type;
                // first pixel of a line is its own neighbour
                if (line_start) begin
                    last_r = int'(in_r);
                    last_g = int'(in_g);
                    last_b = int'(in_b);
                end
                exp_r_q.push_back(model_channel(pixel_sel, int'(in_r), last_r));
                exp_g_q.push_back(model_channel(pixel_sel, int'(in_g), last_g));
                exp_b_q.push_back(model_channel(pixel_sel, int'(in_b), last_b));
                entry_q.push_back(cycle);
                last_r = int'(in_r);
                last_g = int'(in_g);
                last_b = int'(in_b);
            end
        end
        in_flight = exp_r_q.size();
    end

endmodule

//--- tb_image_filter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench top for the image filter processing side
// drives keys and a random pixel stream on the falling edge, random values
// come from a galois lfsr, tb_checker does the comparing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_image_filter;

    localparam int HOLD_CYCLES   = 30;
    localparam int GLITCHES      = 12;
    localparam int STREAM_PIXELS = 40;
    localparam int LONG_PIXELS   = 60;
    localparam int MAX_GAP       = 3;

    // upper bounds of each test in cycles
    localparam int SELECT_LEN  = 2 * HOLD_CYCLES + 2;
    localparam int STREAM_MAX  = STREAM_PIXELS * (MAX_GAP + 1) + 4;
    localparam int LONG_MAX    = LONG_PIXELS * (MAX_GAP + 1) + 4;
    localparam int T1_LEN      = 8 + STREAM_MAX;
    localparam int T2_LEN      = filter_pkg::KEY_COUNT * SELECT_LEN;
    localparam int T3_LEN      = GLITCHES * (8 + 19) + 2;
    localparam int T4_LEN      = 2 * SELECT_LEN;
    localparam int T5_LEN      = filter_pkg::KEY_COUNT * (SELECT_LEN + STREAM_MAX);
    localparam int T6_LEN      = 10 + 2 * SELECT_LEN + LONG_MAX;
    localparam int CYCLE_LIMIT = T1_LEN + T2_LEN + T3_LEN + T4_LEN + T5_LEN + T6_LEN + 100;

    logic                             clk = 1'b0;
    logic                             reset;
    logic [filter_pkg::KEY_COUNT-1:0] key;
    logic                             pixel_valid;
    logic                             line_start;
    logic [filter_pkg::PIXEL_W-1:0]   in_r;
    logic [filter_pkg::PIXEL_W-1:0]   in_g;
    logic [filter_pkg::PIXEL_W-1:0]   in_b;
    logic                             out_valid;
    logic [filter_pkg::PIXEL_W-1:0]   out_r;
    logic [filter_pkg::PIXEL_W-1:0]   out_g;
    logic [filter_pkg::PIXEL_W-1:0]   out_b;
    filter_pkg::filter_e              filter_type;
    logic                             check_sel;
    int                               error_count;
    int                               check_count;
    int                               in_flight;
    int                               cycle_count = 0;
    int                               test_count = 0;
    int                               errors_at_start = 0;
    logic [15:0]                      lfsr_state;

    always #5 clk = ~clk;

    image_filter_top i_image_filter_top (.*);

    tb_checker i_tb_checker (.*);

    // run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    // 16 bit galois lfsr, right shifting
    function automatic logic [15:0] next_lfsr(input logic [15:0] state);
        logic [15:0] shifted;
        shifted = state >> 1;
        if (state[0]) begin
            shifted = shifted ^ 16'hB400;
        end
        return shifted;
    endfunction

    // one lfsr step per bit taken
    function automatic int random_bits(input int count);
        int value;
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = next_lfsr(lfsr_state);
        end
        return value;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic check_selection();
        check_sel = 1'b1;
        @(negedge clk);
        check_sel = 1'b0;
    endtask

    // hold, check the selection while still held, then release
    task automatic select_key(input int mask);
        key = filter_pkg::KEY_COUNT'(mask);
        wait_cycles(HOLD_CYCLES);
        check_selection();
        key = '0;
        wait_cycles(HOLD_CYCLES);
    endtask

    task automatic glitch_key();
        int k;
        int len;
        int gap;
        k   = random_bits(2);
        len = 1 + random_bits(3);
        gap = 4 + random_bits(4);
        key[k] = 1'b1;
        wait_cycles(len);
        key[k] = 1'b0;
        wait_cycles(gap);
    endtask

    // random pixels with random idle gaps, first pixel always opens a line
    task automatic stream_pixels(input int n);
        int gap;
        for (int i = 0; i < n; i++) begin
            gap = random_bits(2);
            pixel_valid = 1'b0;
            line_start  = 1'b0;
            wait_cycles(gap);
            pixel_valid = 1'b1;
            line_start  = (i == 0) || (random_bits(3) == 0);
            in_r = filter_pkg::PIXEL_W'(random_bits(filter_pkg::PIXEL_W));
            in_g = filter_pkg::PIXEL_W'(random_bits(filter_pkg::PIXEL_W));
            in_b = filter_pkg::PIXEL_W'(random_bits(filter_pkg::PIXEL_W));
            @(negedge clk);
        end
        pixel_valid = 1'b0;
        line_start  = 1'b0;
        // drain the pipeline
        while (in_flight != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic finish_test(input string name);
        test_count++;
        $display("test %0d %s: %0d errors", test_count, name, error_count - errors_at_start);
        errors_at_start = error_count;
    endtask

    initial begin
        int a;
        int b;
        reset       = 1'b1;
        key         = '0;
        pixel_valid = 1'b0;
        line_start  = 1'b0;
        in_r        = '0;
        in_g        = '0;
        in_b        = '0;
        check_sel   = 1'b0;
        lfsr_state  = 16'd5241;
        wait_cycles(5);
        reset = 1'b0;

        check_selection();
        stream_pixels(STREAM_PIXELS);
        check_selection();
        finish_test("reset and pass through");

        // order 1 2 3 0 so every press shows a change
        for (int k = 0; k < filter_pkg::KEY_COUNT; k++) begin
            select_key(1 << ((k + 1) % filter_pkg::KEY_COUNT));
        end
        finish_test("key selection");

        repeat (GLITCHES) glitch_key();
        check_selection();
        finish_test("key glitches");

        repeat (2) begin
            a = random_bits(2);
            b = (a + 1 + random_bits(1)) % filter_pkg::KEY_COUNT;
            select_key((1 << a) | (1 << b));
        end
        finish_test("two keys together");

        for (int k = 0; k < filter_pkg::KEY_COUNT; k++) begin
            select_key(1 << k);
            stream_pixels(STREAM_PIXELS);
        end
        finish_test("filters on random pixels");

        // keys picked before the fork so the lfsr order stays fixed
        a = 1 + random_bits(1);
        b = a + 1;
        fork
            stream_pixels(LONG_PIXELS);
            begin
                wait_cycles(10);
                select_key(1 << a);
                select_key(1 << b);
            end
        join
        finish_test("filter change while streaming");

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
